/* verilog/board_bus_pkg.sv */
package board_bus_pkg;

    // bus and storage widths
    typedef logic [63:0] xlen_t; // bus address or data item
    typedef logic [31:0] word_t; // ram word, plic register

    // load/store type from the core, stores only use the first four
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_t;

    // target latched by the sequencer at the enable edge
    typedef enum logic [1:0] {
        SEL_NONE,     // unmapped, completes like a register
        SEL_RAM,
        SEL_PLIC,
        SEL_MTIMECMP
    } tgt_sel_t;

    // word ram, 4 KiB
    localparam xlen_t RAM_BASE    = 64'h0000_0000_8000_0000;
    localparam int    RAM_WORDS   = 1024;
    localparam int    RAM_INDEX_W = $clog2(RAM_WORDS);

    typedef logic [RAM_INDEX_W-1:0] ram_index_t;

    // timer compare
    localparam xlen_t MTIMECMP_ADDR  = 64'h0000_0000_0200_4000;
    localparam xlen_t MTIMECMP_RESET = 64'h0000_0000_8000_0000;

    // plic region, offsets are relative to PLIC_BASE
    localparam xlen_t PLIC_BASE          = 64'h0000_0000_0C00_0000;
    localparam xlen_t PLIC_PENDING_OFS   = 64'h1000;
    localparam xlen_t PLIC_ENABLE_OFS    = 64'h2000;
    localparam xlen_t PLIC_ENABLE_STRIDE = 64'h80;      // per context
    localparam xlen_t PLIC_THRESHOLD_OFS = 64'h20_0000;
    localparam xlen_t PLIC_CTX_STRIDE    = 64'h1000;    // threshold/claim per context
    localparam xlen_t PLIC_CLAIM_OFS     = 64'h20_0004;
    localparam xlen_t PLIC_SPAN          = 64'h40_0000;

    // plic sizes
    localparam int PLIC_SOURCES  = 6;
    localparam int PLIC_CONTEXTS = 2; // 0 is M-mode, 1 is S-mode
    localparam int EXT_IRQ_ID    = 1;

    typedef logic [2:0] plic_prio_t;

endpackage

/* verilog/periph_if.sv */
`timescale 1ns/10ps

// one target port behind the bus sequencer
interface periph_if;

    logic                     rd;      // level, held until ack
    logic                     wr;      // level, held until ack
    board_bus_pkg::xlen_t     ofs;     // byte offset inside the target region
    board_bus_pkg::xlen_t     wdata;
    board_bus_pkg::ls_type_t  ls_type;
    board_bus_pkg::xlen_t     rdata;   // valid while ack is high
    logic                     ack;     // single cycle pulse

    modport sequencer (
        output rd,
        output wr,
        output ofs,
        output wdata,
        output ls_type,
        input  rdata,
        input  ack
    );

    modport target (
        input  rd,
        input  wr,
        input  ofs,
        input  wdata,
        input  ls_type,
        output rdata,
        output ack
    );

endinterface

/* verilog/bus_sequencer.sv */
`timescale 1ns/10ps

module bus_sequencer (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  board_bus_pkg::xlen_t    bus_address,
    input  board_bus_pkg::xlen_t    bus_write_data,
    input  logic                    bus_read_enable,
    input  logic                    bus_write_enable,
    input  board_bus_pkg::ls_type_t bus_ls_type,
    output board_bus_pkg::xlen_t    bus_read_data,
    output logic                    bus_read_done,
    output logic                    bus_write_done,
    periph_if.sequencer             ram,
    periph_if.sequencer             plic
);

    board_bus_pkg::tgt_sel_t sel_d;
    board_bus_pkg::tgt_sel_t sel_q;     // target of the access in flight
    board_bus_pkg::xlen_t    mtimecmp;
    board_bus_pkg::xlen_t    tgt_rdata;
    logic                    tgt_ack;
    logic                    ram_hit;
    logic                    plic_hit;
    logic                    mtimecmp_hit;
    logic                    busy;

    assign ram_hit = (bus_address >= board_bus_pkg::RAM_BASE) &&
                     (bus_address < board_bus_pkg::RAM_BASE +
                      board_bus_pkg::xlen_t'(board_bus_pkg::RAM_WORDS * 4));
    assign plic_hit = (bus_address >= board_bus_pkg::PLIC_BASE) &&
                      (bus_address < board_bus_pkg::PLIC_BASE + board_bus_pkg::PLIC_SPAN);
    assign mtimecmp_hit = (bus_address == board_bus_pkg::MTIMECMP_ADDR);

    always_comb begin
        if (ram_hit) begin
            sel_d = board_bus_pkg::SEL_RAM;
        end else if (plic_hit) begin
            sel_d = board_bus_pkg::SEL_PLIC;
        end else if (mtimecmp_hit) begin
            sel_d = board_bus_pkg::SEL_MTIMECMP;
        end else begin
            sel_d = board_bus_pkg::SEL_NONE;
        end
    end

    // master holds address, type and data until done, so these can follow the bus
    assign ram.ofs      = bus_address - board_bus_pkg::RAM_BASE;
    assign ram.wdata    = bus_write_data;
    assign ram.ls_type  = bus_ls_type;
    assign plic.ofs     = bus_address - board_bus_pkg::PLIC_BASE;
    assign plic.wdata   = bus_write_data;
    assign plic.ls_type = bus_ls_type;

    assign busy = !bus_read_done || !bus_write_done;

    // local registers and unmapped space answer right away
    always_comb begin
        case (sel_q)
            board_bus_pkg::SEL_RAM: begin
                tgt_ack   = ram.ack;
                tgt_rdata = ram.rdata;
            end
            board_bus_pkg::SEL_PLIC: begin
                tgt_ack   = plic.ack;
                tgt_rdata = plic.rdata;
            end
            board_bus_pkg::SEL_MTIMECMP: begin
                tgt_ack   = 1'b1;
                tgt_rdata = mtimecmp;
            end
            default: begin
                tgt_ack   = 1'b1;
                tgt_rdata = '0;     // unmapped reads as zero
            end
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sel_q          <= board_bus_pkg::SEL_NONE;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            ram.rd         <= 1'b0;
            ram.wr         <= 1'b0;
            plic.rd        <= 1'b0;
            plic.wr        <= 1'b0;
            mtimecmp       <= board_bus_pkg::MTIMECMP_RESET;
        end else begin
            // completion, levels drop at the same edge that sees ack
            if (busy && tgt_ack) begin
                ram.rd         <= 1'b0;
                ram.wr         <= 1'b0;
                plic.rd        <= 1'b0;
                plic.wr        <= 1'b0;
                bus_read_done  <= 1'b1;
                bus_write_done <= 1'b1;
                if (!bus_write_done && sel_q == board_bus_pkg::SEL_MTIMECMP) begin
                    mtimecmp <= bus_write_data;
                end
            end
            if (bus_read_enable) begin
                sel_q         <= sel_d;
                bus_read_done <= 1'b0;
                ram.rd        <= (sel_d == board_bus_pkg::SEL_RAM);
                plic.rd       <= (sel_d == board_bus_pkg::SEL_PLIC);
            end
            if (bus_write_enable) begin
                sel_q          <= sel_d;
                bus_write_done <= 1'b0;
                ram.wr         <= (sel_d == board_bus_pkg::SEL_RAM);
                plic.wr        <= (sel_d == board_bus_pkg::SEL_PLIC);
            end
        end
    end

    // read data holds until the next read completes
    always_ff @(posedge CLOCK_50) begin
        if (!bus_read_done && tgt_ack) begin
            bus_read_data <= tgt_rdata;
        end
    end

endmodule

/* verilog/ram_port.sv */
`timescale 1ns/10ps

module ram_port (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    periph_if.target  bus
);

    board_bus_pkg::word_t      mem [board_bus_pkg::RAM_WORDS];
    board_bus_pkg::word_t      rd_word;     // synchronous read port
    board_bus_pkg::word_t      lo_word;     // low half of a double load
    board_bus_pkg::word_t      shifted;
    board_bus_pkg::word_t      store_word;
    board_bus_pkg::ram_index_t base_index;
    board_bus_pkg::ram_index_t index;
    logic [3:0]                byte_en;
    logic [1:0]                lane;
    logic                      step;        // second word of a double
    logic                      access;

    assign access     = (bus.rd || bus.wr) && !bus.ack;
    assign lane       = bus.ofs[1:0];
    assign base_index = bus.ofs[2 +: board_bus_pkg::RAM_INDEX_W];
    assign index      = base_index + board_bus_pkg::ram_index_t'(step);

    // store lanes, data replicated so any enabled lane sees the right bytes
    always_comb begin
        case (bus.ls_type)
            board_bus_pkg::LS_B: begin
                byte_en    = 4'b0001 << lane;
                store_word = {4{bus.wdata[7:0]}};
            end
            board_bus_pkg::LS_H: begin
                byte_en    = 4'b0011 << lane;
                store_word = {2{bus.wdata[15:0]}};
            end
            board_bus_pkg::LS_D: begin
                byte_en    = 4'b1111;
                store_word = step ? bus.wdata[63:32] : bus.wdata[31:0];
            end
            default: begin
                byte_en    = 4'b1111;
                store_word = bus.wdata[31:0];
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (access && bus.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[index][8*b +: 8] <= store_word[8*b +: 8];
                end
            end
        end
        rd_word <= mem[index];
        if (step) begin
            lo_word <= rd_word; // word read in step 0
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            step    <= 1'b0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= 1'b0;
            if (access) begin
                if (bus.ls_type == board_bus_pkg::LS_D && !step) begin
                    step <= 1'b1;
                end else begin
                    step    <= 1'b0;
                    bus.ack <= 1'b1;
                end
            end
        end
    end

    // load extension from the registered word
    assign shifted = rd_word >> {lane, 3'b000};

    always_comb begin
        case (bus.ls_type)
            board_bus_pkg::LS_B:  bus.rdata = {{56{shifted[7]}}, shifted[7:0]};
            board_bus_pkg::LS_BU: bus.rdata = {56'd0, shifted[7:0]};
            board_bus_pkg::LS_H:  bus.rdata = {{48{shifted[15]}}, shifted[15:0]};
            board_bus_pkg::LS_HU: bus.rdata = {48'd0, shifted[15:0]};
            board_bus_pkg::LS_W:  bus.rdata = {{32{shifted[31]}}, shifted};
            board_bus_pkg::LS_D:  bus.rdata = {rd_word, lo_word};
            default:              bus.rdata = {32'd0, shifted};
        endcase
    end

endmodule

/* verilog/plic.sv */
`timescale 1ns/10ps

module plic (
    input  logic      CLOCK_50,
    input  logic      KEY0,
    input  logic      ext_irq,
    periph_if.target  bus,
    output logic      meip_interrupt,
    output logic      msip_interrupt
);

    board_bus_pkg::plic_prio_t prio [board_bus_pkg::PLIC_SOURCES];
    board_bus_pkg::plic_prio_t threshold [board_bus_pkg::PLIC_CONTEXTS];
    board_bus_pkg::word_t      enable [board_bus_pkg::PLIC_CONTEXTS];
    board_bus_pkg::word_t      claim [board_bus_pkg::PLIC_CONTEXTS];
    board_bus_pkg::word_t      pending;
    board_bus_pkg::xlen_t      read_mux;
    logic [board_bus_pkg::PLIC_CONTEXTS-1:0] enable_hit;
    logic [board_bus_pkg::PLIC_CONTEXTS-1:0] threshold_hit;
    logic [board_bus_pkg::PLIC_CONTEXTS-1:0] claim_hit;
    logic [$clog2(board_bus_pkg::PLIC_SOURCES)-1:0] prio_idx;
    logic                      prio_hit;
    logic                      irq_sync;
    logic                      irq_prev;
    logic                      access;

    assign access   = (bus.rd || bus.wr) && !bus.ack;
    assign prio_idx = bus.ofs[2 +: $bits(prio_idx)];
    assign prio_hit = bus.ofs < board_bus_pkg::xlen_t'(board_bus_pkg::PLIC_SOURCES * 4);

    // priority and threshold do not gate the only source
    always_comb begin
        for (int c = 0; c < board_bus_pkg::PLIC_CONTEXTS; c++) begin
            claim[c] = '0;
            if (pending[board_bus_pkg::EXT_IRQ_ID] && enable[c][board_bus_pkg::EXT_IRQ_ID]) begin
                claim[c] = board_bus_pkg::word_t'(board_bus_pkg::EXT_IRQ_ID);
            end
        end
    end

    assign meip_interrupt = (claim[0] != '0);
    assign msip_interrupt = (claim[1] != '0);

    always_comb begin
        read_mux = '0;
        if (prio_hit) begin
            read_mux = board_bus_pkg::xlen_t'(prio[prio_idx]);
        end
        if (bus.ofs == board_bus_pkg::PLIC_PENDING_OFS) begin
            read_mux = board_bus_pkg::xlen_t'(pending);
        end
        for (int c = 0; c < board_bus_pkg::PLIC_CONTEXTS; c++) begin
            enable_hit[c]    = bus.ofs == board_bus_pkg::PLIC_ENABLE_OFS +
                               board_bus_pkg::xlen_t'(c) * board_bus_pkg::PLIC_ENABLE_STRIDE;
            threshold_hit[c] = bus.ofs == board_bus_pkg::PLIC_THRESHOLD_OFS +
                               board_bus_pkg::xlen_t'(c) * board_bus_pkg::PLIC_CTX_STRIDE;
            claim_hit[c]     = bus.ofs == board_bus_pkg::PLIC_CLAIM_OFS +
                               board_bus_pkg::xlen_t'(c) * board_bus_pkg::PLIC_CTX_STRIDE;
            if (enable_hit[c]) read_mux = board_bus_pkg::xlen_t'(enable[c]);
            if (threshold_hit[c]) read_mux = board_bus_pkg::xlen_t'(threshold[c]);
            if (claim_hit[c]) read_mux = board_bus_pkg::xlen_t'(claim[c]);
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < board_bus_pkg::PLIC_SOURCES; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < board_bus_pkg::PLIC_CONTEXTS; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
            pending  <= '0;
            irq_sync <= 1'b0;
            irq_prev <= 1'b0;
            bus.ack  <= 1'b0;
        end else begin
            irq_sync <= ext_irq;    // async line from the uart
            irq_prev <= irq_sync;
            bus.ack  <= access;
            if (access && bus.wr) begin
                if (prio_hit) prio[prio_idx] <= board_bus_pkg::plic_prio_t'(bus.wdata);
                for (int c = 0; c < board_bus_pkg::PLIC_CONTEXTS; c++) begin
                    if (enable_hit[c]) enable[c] <= bus.wdata[31:0];
                    if (threshold_hit[c]) threshold[c] <= board_bus_pkg::plic_prio_t'(bus.wdata);
                end
            end
            // a claim read retires the source it returns
            if (access && bus.rd) begin
                for (int c = 0; c < board_bus_pkg::PLIC_CONTEXTS; c++) begin
                    if (claim_hit[c] && claim[c] != '0) pending[claim[c][4:0]] <= 1'b0;
                end
            end
            if (irq_sync && !irq_prev) pending[board_bus_pkg::EXT_IRQ_ID] <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (access) begin
            bus.rdata <= read_mux; // sampled before the claim clears pending
        end
    end

endmodule

/* verilog/board_bus.sv */
`timescale 1ns/10ps

module board_bus (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  board_bus_pkg::xlen_t    bus_address,
    input  board_bus_pkg::xlen_t    bus_write_data,
    input  logic                    bus_read_enable,
    input  logic                    bus_write_enable,
    input  board_bus_pkg::ls_type_t bus_ls_type,
    input  logic                    ext_irq,        // uart irq line
    output board_bus_pkg::xlen_t    bus_read_data,
    output logic                    bus_read_done,
    output logic                    bus_write_done,
    output logic                    meip_interrupt,
    output logic                    msip_interrupt
);

    periph_if ram_bus ();
    periph_if plic_bus ();

    // address decode, done levels and mtimecmp
    bus_sequencer bus_sequencer_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_ls_type      (bus_ls_type),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram              (ram_bus),
        .plic             (plic_bus)
    );

    ram_port ram_port_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (ram_bus)
    );

    plic plic_i (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .ext_irq        (ext_irq),
        .bus            (plic_bus),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

/* test/board_bus_model.svh */
`ifndef BOARD_BUS_MODEL_SVH
`define BOARD_BUS_MODEL_SVH

// shadow copies of the ram and plic state written by the tests
board_bus_pkg::word_t shadow_ram [board_bus_pkg::RAM_WORDS];
board_bus_pkg::word_t shadow_enable [board_bus_pkg::PLIC_CONTEXTS];
logic                 shadow_pending;   // source 1 is the only source

function automatic int word_index(board_bus_pkg::xlen_t addr);
    return int'(((addr - board_bus_pkg::RAM_BASE) >> 2) % 64'(board_bus_pkg::RAM_WORDS));
endfunction

function automatic int access_bytes(board_bus_pkg::ls_type_t ls);
    case (ls)
        board_bus_pkg::LS_B, board_bus_pkg::LS_BU: return 1;
        board_bus_pkg::LS_H, board_bus_pkg::LS_HU: return 2;
        board_bus_pkg::LS_D: return 8;
        default: return 4;
    endcase
endfunction

// lane picked by the low address bits, then sign or zero extension
function automatic board_bus_pkg::xlen_t load_reference(board_bus_pkg::xlen_t addr,
                                                        board_bus_pkg::ls_type_t ls);
    board_bus_pkg::word_t w;
    logic [7:0]           b;
    logic [15:0]          h;
    w = shadow_ram[word_index(addr)];
    b = 8'(w >> (8 * addr[1:0]));
    h = 16'(w >> (8 * addr[1:0]));
    case (ls)
        board_bus_pkg::LS_B:  return {{56{b[7]}}, b};
        board_bus_pkg::LS_BU: return {56'd0, b};
        board_bus_pkg::LS_H:  return {{48{h[15]}}, h};
        board_bus_pkg::LS_HU: return {48'd0, h};
        board_bus_pkg::LS_W:  return {{32{w[31]}}, w};
        board_bus_pkg::LS_D:
            return {shadow_ram[(word_index(addr) + 1) % board_bus_pkg::RAM_WORDS], w};
        default: return {32'd0, w};
    endcase
endfunction

function automatic void shadow_store(board_bus_pkg::xlen_t addr,
                                     board_bus_pkg::ls_type_t ls,
                                     board_bus_pkg::xlen_t data);
    int idx;
    idx = word_index(addr);
    case (ls)
        board_bus_pkg::LS_B: shadow_ram[idx][8 * int'(addr[1:0]) +: 8] = data[7:0];
        board_bus_pkg::LS_H: shadow_ram[idx][8 * int'(addr[1:0]) +: 16] = data[15:0];
        board_bus_pkg::LS_D: begin
            shadow_ram[idx] = data[31:0];
            shadow_ram[(idx + 1) % board_bus_pkg::RAM_WORDS] = data[63:32]; // second word
        end
        default: shadow_ram[idx] = data[31:0];
    endcase
endfunction

// claim ignores priority and threshold
function automatic board_bus_pkg::xlen_t claim_reference(int ctx);
    if (shadow_pending && shadow_enable[ctx][board_bus_pkg::EXT_IRQ_ID]) begin
        return board_bus_pkg::xlen_t'(board_bus_pkg::EXT_IRQ_ID);
    end
    return '0;
endfunction

`endif

/* test/board_bus_tb.sv */
`timescale 1ns/10ps

module board_bus_tb;

    logic                    CLOCK_50;
    logic                    KEY0;
    board_bus_pkg::xlen_t    bus_address;
    board_bus_pkg::xlen_t    bus_write_data;
    logic                    bus_read_enable;
    logic                    bus_write_enable;
    board_bus_pkg::ls_type_t bus_ls_type;
    logic                    ext_irq;
    board_bus_pkg::xlen_t    bus_read_data;
    logic                    bus_read_done;
    logic                    bus_write_done;
    logic                    meip_interrupt;
    logic                    msip_interrupt;

    integer                  seed;
    int                      issued;            // accesses started so far
    int                      cycles;
    logic                    read_done_prev;
    string                   name_q [$];
    board_bus_pkg::xlen_t    exp_q [$];         // expected data of reads in flight
    board_bus_pkg::ls_type_t load_types [6] = '{board_bus_pkg::LS_B, board_bus_pkg::LS_BU,
        board_bus_pkg::LS_H, board_bus_pkg::LS_HU, board_bus_pkg::LS_W, board_bus_pkg::LS_WU};

    `include "board_bus_model.svh"

    board_bus board_bus_i (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input string name, input board_bus_pkg::xlen_t expected,
                              input board_bus_pkg::xlen_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED %s: expected %h, actual %h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED %s: expected %b, actual %b",
                                        name, expected, actual));
        end
    endtask

    task automatic bus_read(input board_bus_pkg::xlen_t addr, input board_bus_pkg::ls_type_t ls,
                            input board_bus_pkg::xlen_t expected, input string name);
        name_q.push_back(name);
        exp_q.push_back(expected);
        bus_address     = addr;
        bus_ls_type     = ls;
        bus_read_enable = 1'b1;
        issued++;
        @(posedge CLOCK_50);
        #2 bus_read_enable = 1'b0;
        @(negedge CLOCK_50);
        check_level($sformatf("%s read done low", name), 1'b0, bus_read_done);
        while (!bus_read_done) @(negedge CLOCK_50);
        @(posedge CLOCK_50);
        #2;
    endtask

    task automatic bus_write(input board_bus_pkg::xlen_t addr, input board_bus_pkg::ls_type_t ls,
                             input board_bus_pkg::xlen_t data);
        bus_address      = addr;
        bus_ls_type      = ls;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        issued++;
        @(posedge CLOCK_50);
        #2 bus_write_enable = 1'b0;
        @(negedge CLOCK_50);
        check_level($sformatf("write %h done low", addr), 1'b0, bus_write_done);
        while (!bus_write_done) @(negedge CLOCK_50);
        @(posedge CLOCK_50);
        #2;
    endtask

    task automatic ram_write(input board_bus_pkg::xlen_t addr, input board_bus_pkg::ls_type_t ls,
                             input board_bus_pkg::xlen_t data);
        bus_write(addr, ls, data);
        shadow_store(addr, ls, data);
    endtask

    function automatic board_bus_pkg::xlen_t random_ram_addr(input int align_words);
        int unsigned idx;
        idx = $unsigned($random(seed)) % board_bus_pkg::RAM_WORDS;
        idx = idx - idx % align_words;
        return board_bus_pkg::RAM_BASE + board_bus_pkg::xlen_t'(idx * 4);
    endfunction

    function automatic board_bus_pkg::xlen_t random_data();
        return {$random(seed), $random(seed)};
    endfunction

    // compare each read on the falling edge after its done rises
    always @(negedge CLOCK_50) begin
        if (KEY0 && bus_read_done && !read_done_prev) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("read done rose with no read outstanding");
            end else begin
                check_data(name_q.pop_front(), exp_q.pop_front(), bus_read_data);
            end
        end
        read_done_prev = bus_read_done;
    end

    initial begin
        cycles = 0;
        while (cycles <= 200 * issued + 100) begin
            @(posedge CLOCK_50);
            cycles++;
        end
        stop_with_failure($sformatf("timeout after %0d cycles, a bus access never finished",
                                    cycles));
    end

    initial begin
        board_bus_pkg::xlen_t addr;
        board_bus_pkg::xlen_t data;
        board_bus_pkg::xlen_t plic_en1;
        seed             = 32'h2c27;
        issued           = 0;
        read_done_prev   = 1'b1;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        bus_ls_type      = board_bus_pkg::LS_W;
        ext_irq          = 1'b0;
        shadow_enable    = '{default: '0};
        shadow_pending   = 1'b0;
        repeat (4) @(posedge CLOCK_50);
        #2 KEY0 = 1'b1;
        check_level("read done after reset", 1'b1, bus_read_done);
        check_level("write done after reset", 1'b1, bus_write_done);

        // random words, then every load type at each aligned offset
        for (int n = 0; n < 4; n++) begin
            addr = random_ram_addr(1);
            ram_write(addr, board_bus_pkg::LS_W, random_data());
            for (int ofs = 0; ofs < 4; ofs++) begin
                foreach (load_types[t]) begin
                    if (ofs % access_bytes(load_types[t]) == 0) begin
                        bus_read(addr + board_bus_pkg::xlen_t'(ofs), load_types[t],
                                 load_reference(addr + board_bus_pkg::xlen_t'(ofs), load_types[t]),
                                 $sformatf("ram %s ofs %0d", load_types[t].name(), ofs));
                    end
                end
            end
        end

        // byte and half lanes merged into a known word
        addr = random_ram_addr(1);
        ram_write(addr, board_bus_pkg::LS_W, 64'h1122_3344);
        ram_write(addr + 64'd1, board_bus_pkg::LS_B, 64'hA5);
        ram_write(addr + 64'd2, board_bus_pkg::LS_H, 64'hBEEF);
        bus_read(addr, board_bus_pkg::LS_W, load_reference(addr, board_bus_pkg::LS_W),
                 "store merge");

        addr = random_ram_addr(2);
        data = random_data();
        ram_write(addr, board_bus_pkg::LS_D, data);
        bus_read(addr, board_bus_pkg::LS_D, data, "double load");
        bus_read(addr, board_bus_pkg::LS_WU, {32'd0, data[31:0]}, "double low word");
        bus_read(addr + 64'd4, board_bus_pkg::LS_WU, {32'd0, data[63:32]}, "double high word");

        bus_read(board_bus_pkg::MTIMECMP_ADDR, board_bus_pkg::LS_D,
                 board_bus_pkg::MTIMECMP_RESET, "mtimecmp reset");
        data = random_data();
        bus_write(board_bus_pkg::MTIMECMP_ADDR, board_bus_pkg::LS_D, data);
        bus_read(board_bus_pkg::MTIMECMP_ADDR, board_bus_pkg::LS_D, data, "mtimecmp readback");
        bus_read(64'h1000_0000, board_bus_pkg::LS_D, '0, "unmapped read");

        // ext irq edge through claim on the plic
        bus_write(board_bus_pkg::PLIC_BASE + board_bus_pkg::PLIC_ENABLE_OFS,
                  board_bus_pkg::LS_W, 64'h2);
        shadow_enable[0] = 32'h2;
        ext_irq          = 1'b1;
        shadow_pending   = 1'b1;
        for (int n = 0; n < 8 && !meip_interrupt; n++) begin
            @(negedge CLOCK_50);    // sync and edge capture take a few cycles
        end
        check_level("meip after irq edge", claim_reference(0) != '0, meip_interrupt);
        check_level("msip after irq edge", claim_reference(1) != '0, msip_interrupt);
        @(posedge CLOCK_50);
        #2;
        bus_read(board_bus_pkg::PLIC_BASE + board_bus_pkg::PLIC_CLAIM_OFS,
                 board_bus_pkg::LS_WU, claim_reference(0), "first claim");
        shadow_pending = 1'b0;
        check_level("meip after claim", claim_reference(0) != '0, meip_interrupt);
        bus_read(board_bus_pkg::PLIC_BASE + board_bus_pkg::PLIC_CLAIM_OFS,
                 board_bus_pkg::LS_WU, claim_reference(0), "second claim");

        plic_en1 = board_bus_pkg::PLIC_BASE + board_bus_pkg::PLIC_ENABLE_OFS +
                   board_bus_pkg::PLIC_ENABLE_STRIDE;
        data = random_data();
        bus_write(plic_en1, board_bus_pkg::LS_W, data);
        shadow_enable[1] = data[31:0];
        bus_read(plic_en1, board_bus_pkg::LS_WU, {32'd0, data[31:0]}, "enable readback");
        addr = board_bus_pkg::PLIC_BASE + board_bus_pkg::PLIC_THRESHOLD_OFS +
               board_bus_pkg::PLIC_CTX_STRIDE;
        bus_write(addr, board_bus_pkg::LS_W, data);
        bus_read(addr, board_bus_pkg::LS_WU, data & 64'h7, "threshold readback");
        bus_write(board_bus_pkg::PLIC_BASE + 64'd12, board_bus_pkg::LS_W, data >> 8);
        bus_read(board_bus_pkg::PLIC_BASE + 64'd12, board_bus_pkg::LS_WU, (data >> 8) & 64'h7,
                 "priority readback");

        if (exp_q.size() != 0) begin
            stop_with_failure("reads left without a comparison at the end of the run");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* board_bus.f */
verilog/board_bus_pkg.sv
verilog/periph_if.sv
verilog/bus_sequencer.sv
verilog/ram_port.sv
verilog/plic.sv
verilog/board_bus.sv
test/board_bus_tb.sv
+incdir+test

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module board_bus_tb -f board_bus.f
./obj_dir/Vboard_bus_tb
